/* mips_isa_pkg.sv */
package mips_isa_pkg;

    // major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // r-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        fn_sll = 6'h00,
        fn_srl = 6'h02,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_t;

    // instruction field positions
    localparam int op_hi  = 31;
    localparam int op_lo  = 26;
    localparam int rs_hi  = 25;
    localparam int rs_lo  = 21;
    localparam int rt_hi  = 20;
    localparam int rt_lo  = 16;
    localparam int rd_hi  = 15;
    localparam int rd_lo  = 11;
    localparam int sh_hi  = 10;
    localparam int sh_lo  = 6;
    localparam int fn_hi  = 5;
    localparam int fn_lo  = 0;
    localparam int imm_hi = 15;
    localparam int imm_lo = 0;

    localparam logic [31:0] reset_pc = 32'h0000_0000;
    localparam logic [31:0] nop_word = 32'h0000_0000; // sll $0, $0, 0

endpackage

/* mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

    // operation carried down to the execute stage
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_slt = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6
    } alu_op_t;

    // destination register select, 3 bits wide as in the older pipeline
    typedef enum logic [2:0] {
        dst_rt = 3'd0,
        dst_rd = 3'd1
    } regdst_t;

    // write-back source
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1
    } wb_src_t;

endpackage

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [1:31]; // $0 has no storage

    // zero register, then write-through bypass, then the array
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end else if (we && (waddr == addr)) begin
            return wdata;
        end else begin
            return regs[addr];
        end
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata; // writes to $0 dropped
        end
    end

    always_comb rdata1 = read_port(raddr1);
    always_comb rdata2 = read_port(raddr2);

endmodule

/* decode_unit.sv */
`timescale 1ns/1ps

module decode_unit
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
    input  logic [31:0] instr,
    output logic        alusrc,
    output logic        regwrite,
    output logic        memwrite,
    output logic        memread,
    output regdst_t     regdst,
    output alu_op_t     aluop,
    output wb_src_t     memtoreg,
    output logic [31:0] sign_ext_offset
);

    opcode_t opcode;
    funct_t  funct;

    assign opcode = opcode_t'(instr[op_hi:op_lo]);
    assign funct  = funct_t'(instr[fn_hi:fn_lo]);

    assign sign_ext_offset = {{16{instr[imm_hi]}}, instr[imm_hi:imm_lo]};

    always_comb begin
        // defaults describe a bubble
        alusrc   = 1'b0;
        regwrite = 1'b0;
        memwrite = 1'b0;
        memread  = 1'b0;
        regdst   = dst_rt;
        aluop    = alu_add;
        memtoreg = wb_alu;

        case (opcode)
            op_rtype: begin
                regdst   = dst_rd;
                regwrite = 1'b1;
                case (funct)
                    fn_add:  aluop = alu_add;
                    fn_sub:  aluop = alu_sub;
                    fn_and:  aluop = alu_and;
                    fn_or:   aluop = alu_or;
                    fn_slt:  aluop = alu_slt;
                    fn_sll:  aluop = alu_sll;
                    fn_srl:  aluop = alu_srl;
                    default: regwrite = 1'b0; // unknown funct, no write
                endcase
            end
            op_addi: begin
                alusrc   = 1'b1;
                regwrite = 1'b1;
            end
            op_lw: begin
                alusrc   = 1'b1;
                regwrite = 1'b1;
                memread  = 1'b1;
                memtoreg = wb_mem;
            end
            op_sw: begin
                alusrc   = 1'b1;
                memwrite = 1'b1;
            end
            // sub with no write and no access marks a branch downstream
            op_beq:  aluop = alu_sub;
            default: ;
        endcase
    end

endmodule

/* id_ex.sv */
`timescale 1ns/1ps

module id_ex
    import mips_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,

    input  logic [31:0] pc_in,
    input  logic [31:0] reg_data1,
    input  logic [31:0] reg_data2,
    input  logic [31:0] sign_ext_offset,
    input  logic [4:0]  rd,
    input  logic [4:0]  rt,
    input  logic [5:0]  func,
    input  logic [4:0]  shamt,

    output logic [31:0] pc_out,
    output logic [31:0] reg_data1_out,
    output logic [31:0] reg_data2_out,
    output logic [31:0] sign_ext_offset_out,
    output logic [4:0]  rd_out,
    output logic [4:0]  rt_out,
    output logic [5:0]  func_out,
    output logic [4:0]  shamt_out,

    // control from decode
    input  logic        alusrc_in,
    input  regdst_t     regdst_in,
    input  logic        regwrite_in,
    input  alu_op_t     aluop_in,
    input  logic        memwrite_in,
    input  logic        memread_in,
    input  wb_src_t     memtoreg_in,

    // control to execute and later stages
    output logic        alusrc_out,
    output regdst_t     regdst_out,
    output logic        regwrite_out,
    output alu_op_t     aluop_out,
    output logic        memwrite_out,
    output logic        memread_out,
    output wb_src_t     memtoreg_out
);

    // operands and fields
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_out              <= 32'd0;
            reg_data1_out       <= 32'd0;
            reg_data2_out       <= 32'd0;
            sign_ext_offset_out <= 32'd0;
            rd_out              <= 5'd0;
            rt_out              <= 5'd0;
            func_out            <= 6'd0;
            shamt_out           <= 5'd0;
        end else begin
            pc_out              <= pc_in;
            reg_data1_out       <= reg_data1;
            reg_data2_out       <= reg_data2;
            sign_ext_offset_out <= sign_ext_offset;
            rd_out              <= rd;
            rt_out              <= rt;
            func_out            <= func;
            shamt_out           <= shamt;
        end
    end

    // control, cleared on flush so the slot turns into a bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alusrc_out   <= 1'b0;
            regdst_out   <= dst_rt;
            regwrite_out <= 1'b0;
            aluop_out    <= alu_add;
            memwrite_out <= 1'b0;
            memread_out  <= 1'b0;
            memtoreg_out <= wb_alu;
        end else if (flush) begin
            alusrc_out   <= 1'b0;
            regdst_out   <= dst_rt;
            regwrite_out <= 1'b0;
            aluop_out    <= alu_add; // not sub, so no branch either
            memwrite_out <= 1'b0;
            memread_out  <= 1'b0;
            memtoreg_out <= wb_alu;
        end else begin
            alusrc_out   <= alusrc_in;
            regdst_out   <= regdst_in;
            regwrite_out <= regwrite_in;
            aluop_out    <= aluop_in;
            memwrite_out <= memwrite_in;
            memread_out  <= memread_in;
            memtoreg_out <= memtoreg_in;
        end
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
    import mips_ctrl_pkg::*;
(
    input  logic [31:0] pc,
    input  logic [31:0] reg_data1,
    input  logic [31:0] reg_data2,
    input  logic [31:0] sign_ext_offset,
    input  logic [4:0]  rd,
    input  logic [4:0]  rt,
    input  logic [4:0]  shamt,
    input  logic        alusrc,
    input  regdst_t     regdst,
    input  alu_op_t     aluop,
    input  logic        is_branch,
    output logic [31:0] alu_result,
    output logic [31:0] store_data,
    output logic [31:0] branch_target,
    output logic [4:0]  dest_reg,
    output logic        branch_taken
);

    logic [31:0] op_a;
    logic [31:0] op_b;

    assign op_a = reg_data1;
    assign op_b = alusrc ? sign_ext_offset : reg_data2; // immediate for addi, lw, sw

    always_comb begin
        case (aluop)
            alu_add: alu_result = op_a + op_b;
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_slt: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            // shifts act on rt by shamt
            alu_sll: alu_result = op_b << shamt;
            alu_srl: alu_result = op_b >> shamt; // logical, zero fill
            default: alu_result = 32'd0;
        endcase
    end

    assign store_data = reg_data2; // sw writes rt

    assign dest_reg = (regdst == dst_rd) ? rd : rt;

    // beq subtracts, equal operands give zero
    assign branch_taken  = is_branch && (alu_result == 32'd0);
    assign branch_target = pc + 32'd4 + {sign_ext_offset[29:0], 2'b00};

endmodule

/* mips_core.sv */
`timescale 1ns/1ps

module mips_core
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic        dmem_we,
    output logic        dmem_re,
    input  logic [31:0] dmem_rdata
);

    logic [31:0] pc;

    // if/id
    logic [31:0] ifid_pc;
    logic [31:0] ifid_instr;

    // decode outputs
    logic        dec_alusrc;
    logic        dec_regwrite;
    logic        dec_memwrite;
    logic        dec_memread;
    regdst_t     dec_regdst;
    alu_op_t     dec_aluop;
    wb_src_t     dec_memtoreg;
    logic [31:0] dec_imm;
    logic [31:0] rf_data1;
    logic [31:0] rf_data2;

    // id/ex outputs
    logic [31:0] ex_pc;
    logic [31:0] ex_data1;
    logic [31:0] ex_data2;
    logic [31:0] ex_imm;
    logic [4:0]  ex_rd;
    logic [4:0]  ex_rt;
    logic [4:0]  ex_shamt;
    logic        ex_alusrc;
    regdst_t     ex_regdst;
    logic        ex_regwrite;
    alu_op_t     ex_aluop;
    logic        ex_memwrite;
    logic        ex_memread;
    wb_src_t     ex_memtoreg;
    logic        ex_is_branch;

    // execute results
    logic [31:0] alu_result;
    logic [31:0] store_data;
    logic [31:0] branch_target;
    logic [4:0]  dest_reg;
    logic        branch_taken;

    // ex/mem
    logic [31:0] exmem_alu;
    logic [31:0] exmem_store;
    logic [4:0]  exmem_dest;
    logic        exmem_regwrite;
    logic        exmem_memwrite;
    logic        exmem_memread;
    wb_src_t     exmem_memtoreg;

    // mem/wb
    logic [31:0] memwb_alu;
    logic [31:0] memwb_rdata;
    logic [4:0]  memwb_dest;
    logic        memwb_regwrite;
    wb_src_t     memwb_memtoreg;
    logic [31:0] wb_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    assign imem_addr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ifid_pc    <= 32'd0;
            ifid_instr <= 32'd0;
        end else begin
            ifid_pc    <= pc;
            ifid_instr <= branch_taken ? nop_word : imem_data; // squash wrong-path fetch
        end
    end

    decode_unit u_decode (
        .instr           (ifid_instr),
        .alusrc          (dec_alusrc),
        .regwrite        (dec_regwrite),
        .memwrite        (dec_memwrite),
        .memread         (dec_memread),
        .regdst          (dec_regdst),
        .aluop           (dec_aluop),
        .memtoreg        (dec_memtoreg),
        .sign_ext_offset (dec_imm)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (ifid_instr[rs_hi:rs_lo]),
        .raddr2 (ifid_instr[rt_hi:rt_lo]),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2),
        .we     (memwb_regwrite),
        .waddr  (memwb_dest),
        .wdata  (wb_data)
    );

    id_ex u_id_ex (
        .clk                 (clk),
        .reset               (reset),
        .flush               (branch_taken),
        .pc_in               (ifid_pc),
        .reg_data1           (rf_data1),
        .reg_data2           (rf_data2),
        .sign_ext_offset     (dec_imm),
        .rd                  (ifid_instr[rd_hi:rd_lo]),
        .rt                  (ifid_instr[rt_hi:rt_lo]),
        .func                (ifid_instr[fn_hi:fn_lo]),
        .shamt               (ifid_instr[sh_hi:sh_lo]),
        .pc_out              (ex_pc),
        .reg_data1_out       (ex_data1),
        .reg_data2_out       (ex_data2),
        .sign_ext_offset_out (ex_imm),
        .rd_out              (ex_rd),
        .rt_out              (ex_rt),
        .func_out            (),
        .shamt_out           (ex_shamt),
        .alusrc_in           (dec_alusrc),
        .regdst_in           (dec_regdst),
        .regwrite_in         (dec_regwrite),
        .aluop_in            (dec_aluop),
        .memwrite_in         (dec_memwrite),
        .memread_in          (dec_memread),
        .memtoreg_in         (dec_memtoreg),
        .alusrc_out          (ex_alusrc),
        .regdst_out          (ex_regdst),
        .regwrite_out        (ex_regwrite),
        .aluop_out           (ex_aluop),
        .memwrite_out        (ex_memwrite),
        .memread_out         (ex_memread),
        .memtoreg_out        (ex_memtoreg)
    );

    // only beq decodes to sub without a write or memory access
    assign ex_is_branch = (ex_aluop == alu_sub) && !ex_regwrite
                          && !ex_memwrite && !ex_memread;

    execute_stage u_execute (
        .pc              (ex_pc),
        .reg_data1       (ex_data1),
        .reg_data2       (ex_data2),
        .sign_ext_offset (ex_imm),
        .rd              (ex_rd),
        .rt              (ex_rt),
        .shamt           (ex_shamt),
        .alusrc          (ex_alusrc),
        .regdst          (ex_regdst),
        .aluop           (ex_aluop),
        .is_branch       (ex_is_branch),
        .alu_result      (alu_result),
        .store_data      (store_data),
        .branch_target   (branch_target),
        .dest_reg        (dest_reg),
        .branch_taken    (branch_taken)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem_alu      <= 32'd0;
            exmem_store    <= 32'd0;
            exmem_dest     <= 5'd0;
            exmem_regwrite <= 1'b0;
            exmem_memwrite <= 1'b0;
            exmem_memread  <= 1'b0;
            exmem_memtoreg <= wb_alu;
        end else begin
            exmem_alu      <= alu_result;
            exmem_store    <= store_data;
            exmem_dest     <= dest_reg;
            exmem_regwrite <= ex_regwrite;
            exmem_memwrite <= ex_memwrite;
            exmem_memread  <= ex_memread;
            exmem_memtoreg <= ex_memtoreg;
        end
    end

    // data memory answers in the same cycle
    assign dmem_addr  = exmem_alu;
    assign dmem_wdata = exmem_store;
    assign dmem_we    = exmem_memwrite;
    assign dmem_re    = exmem_memread;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memwb_alu      <= 32'd0;
            memwb_rdata    <= 32'd0;
            memwb_dest     <= 5'd0;
            memwb_regwrite <= 1'b0;
            memwb_memtoreg <= wb_alu;
        end else begin
            memwb_alu      <= exmem_alu;
            memwb_rdata    <= dmem_rdata;
            memwb_dest     <= exmem_dest;
            memwb_regwrite <= exmem_regwrite;
            memwb_memtoreg <= exmem_memtoreg;
        end
    end

    assign wb_data = (memwb_memtoreg == wb_mem) ? memwb_rdata : memwb_alu;

endmodule

/* mips_core_sva.sv */
`timescale 1ns/1ps

module mips_core_sva (
    input logic        clk,
    input logic        reset,
    input logic [31:0] imem_addr,
    input logic [31:0] dmem_addr,
    input logic        dmem_we,
    input logic        dmem_re,
    input logic        branch_taken
);

    int fail_count = 0; // assertion failures so far

    // no memory strobes in reset or on the first edge after it
    quiet_in_reset: assert property (@(posedge clk) reset |-> !dmem_we && !dmem_re)
        else begin
            $error("dmem strobe active during reset");
            fail_count = fail_count + 1;
        end

    quiet_after_reset: assert property (@(posedge clk) $past(reset) |-> !dmem_we && !dmem_re)
        else begin
            $error("dmem strobe active right after reset");
            fail_count = fail_count + 1;
        end

    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(dmem_we && dmem_re))
        else begin
            $error("dmem_we and dmem_re high together");
            fail_count = fail_count + 1;
        end

    word_aligned: assert property (@(posedge clk) disable iff (reset)
        (dmem_we || dmem_re) |-> dmem_addr[1:0] == 2'b00)
        else begin
            $error("dmem_addr 0x%08h not word aligned", dmem_addr);
            fail_count = fail_count + 1;
        end

    // sequential fetch unless a branch was taken the cycle before
    pc_steps_by_four: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && !$past(branch_taken) |-> imem_addr == $past(imem_addr) + 32'd4)
        else begin
            $error("imem_addr 0x%08h did not step by four", imem_addr);
            fail_count = fail_count + 1;
        end

endmodule

bind mips_core mips_core_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .imem_addr    (imem_addr),
    .dmem_addr    (dmem_addr),
    .dmem_we      (dmem_we),
    .dmem_re      (dmem_re),
    .branch_taken (branch_taken)
);

/* tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core;

    localparam int          mem_words  = 256;
    localparam int          wait_limit = 2000;
    localparam logic [31:0] done_addr  = 32'h0000_03fc;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic        dmem_re;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [0:mem_words-1];
    logic [31:0] dmem [0:mem_words-1];

    int errors;
    int sva_errors;
    bit done_seen;

    mips_core dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    always #10 clk = ~clk;

    // both memories read in the same cycle, 1 KB each
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : 32'hdead_beef; // garbage unless read

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    // every word differs, so a stray store shows up
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return 32'hc0de_0000 ^ ({24'd0, addr[9:2]} * 32'h0001_0001);
    endfunction

    task automatic check_word(input logic [31:0] addr, input logic [31:0] expected);
        logic [31:0] got;
        got = dmem[addr[9:2]];
        assert (got == expected) else begin
            $display("** Error dmem[0x%03h]: got 0x%08h, expected 0x%08h", addr, got, expected);
            errors++;
        end
    endtask

    // expected memory after prog.hex, worked out by hand
    // $1 = 0x30, $2 = -3, $3 = 0x0f0f
    task automatic check_results();
        check_word(32'h100, 32'h0000_002d); // add 0x30 + -3
        check_word(32'h104, 32'h0000_0033); // sub 0x30 - -3
        check_word(32'h108, 32'h0000_0f0d); // and
        check_word(32'h10c, 32'h0000_0f3f); // or
        check_word(32'h110, 32'h0000_0001); // slt, -3 < 0x30
        check_word(32'h114, 32'h0000_0000); // slt, 0x30 < -3 false
        check_word(32'h118, 32'h0000_f0f0); // sll by 4
        check_word(32'h11c, 32'h0000_000f); // srl by 28, zero fill
        check_word(32'h120, 32'h0000_f0f0); // lw of 0x118, stored again
        check_word(32'h124, 32'h0000_0000); // $0 after addi to $0
        // both skipped by the taken beq
        check_word(32'h128, fill_word(32'h128));
        check_word(32'h12c, fill_word(32'h12c));
        check_word(32'h130, 32'h0000_0077); // fall-through of untaken beq
        check_word(32'h134, 32'h0000_0030);
        check_word(done_addr, 32'h0000_0001);
    endtask

    task automatic wait_done_store();
        int cycles;
        cycles = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < wait_limit) begin
            @(negedge clk);
            if (dmem_we && dmem_addr == done_addr && dmem_wdata == 32'd1) begin
                done_seen = 1'b1;
            end
            cycles++;
        end
    endtask

    initial begin
        errors = 0;
        sva_errors = 0;
        clk = 1'b0;
        reset = 1'b1;
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = {6'h3f, 26'(i)}; // unknown opcode, decodes as a bubble
            dmem[i] <= fill_word(32'(i) << 2);
        end
        $readmemh("prog.hex", imem);

        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        wait_done_store();
        if (done_seen) begin
            @(posedge clk); // done store lands here
            #1;
            check_results();
        end else begin
            $display("timeout: no store of 1 to 0x3fc within %0d cycles", wait_limit);
            errors++;
        end

        sva_errors = dut.u_sva.fail_count;
        $display("errors: %0d result check(s), %0d assertion failure(s)", errors, sva_errors);
        if (errors == 0 && sva_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* prog.hex */
// one 32-bit instruction per line in hex, from address 0x000 upward
// dependent instructions are at least two apart, the core has no forwarding
20010030  // 00: addi $1, $0, 0x30
2002fffd  // 04: addi $2, $0, -3
20030f0f  // 08: addi $3, $0, 0x0f0f
20090001  // 0c: addi $9, $0, 1
00222020  // 10: add  $4, $1, $2
00222822  // 14: sub  $5, $1, $2
00623024  // 18: and  $6, $3, $2
00233825  // 1c: or   $7, $1, $3
0041402a  // 20: slt  $8, $2, $1
0022502a  // 24: slt  $10, $1, $2
00035900  // 28: sll  $11, $3, 4
00026702  // 2c: srl  $12, $2, 28
ac040100  // 30: sw   $4, 0x100($0)
ac050104  // 34: sw   $5, 0x104($0)
ac060108  // 38: sw   $6, 0x108($0)
ac07010c  // 3c: sw   $7, 0x10c($0)
ac080110  // 40: sw   $8, 0x110($0)
ac0a0114  // 44: sw   $10, 0x114($0)
ac0b0118  // 48: sw   $11, 0x118($0)
ac0c011c  // 4c: sw   $12, 0x11c($0)
8c0d0118  // 50: lw   $13, 0x118($0)
20000055  // 54: addi $0, $0, 0x55
200e0077  // 58: addi $14, $0, 0x77
ac0d0120  // 5c: sw   $13, 0x120($0)
ac000124  // 60: sw   $0, 0x124($0)
11ce0002  // 64: beq  $14, $14, +2 (taken)
ac090128  // 68: sw   $9, 0x128($0)
ac09012c  // 6c: sw   $9, 0x12c($0)
10220002  // 70: beq  $1, $2, +2 (not taken)
ac0e0130  // 74: sw   $14, 0x130($0)
ac010134  // 78: sw   $1, 0x134($0)
ac0903fc  // 7c: sw   $9, 0x3fc($0)
1000ffff  // 80: beq  $0, $0, -1 (spin)

/* mips_core.f */
mips_isa_pkg.sv
mips_ctrl_pkg.sv
reg_file.sv
decode_unit.sv
id_ex.sv
execute_stage.sv
mips_core.sv
mips_core_sva.sv
tb_mips_core.sv

/* run_sim.sh */
#!/bin/sh
# build tb_mips_core with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_mips_core -f mips_core.f -o sim_mips_core || exit 1
out=$(./obj_dir/sim_mips_core +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }
